// ==== rtl/axiSlave_settings.svh ====
`ifndef AXI_SLAVE_SETTINGS_SVH
`define AXI_SLAVE_SETTINGS_SVH

// AXI-Lite data bus width
`define AXI_DWIDTH 32

// byte strobe width, one bit per data byte
`define AXI_SWIDTH (`AXI_DWIDTH / 8)

// byte address width
`define AXI_AWIDTH 16

// number of 32-bit words in the register bank
`define REG_COUNT 16

// read-only identification word at offset 0
`define REG_ID_VALUE 32'h5A11_0001

`endif

// ==== rtl/axiSlavePkg.sv ====
`default_nettype none

`include "axiSlave_settings.svh"

package axiSlavePkg;

  // AXI response codes, only the two the bank can return
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } respT;

  // one address beat, shared by AW and AR
  typedef struct packed {
    logic [`AXI_AWIDTH-1:0] addr;
  } addrBeatT;

  // one write data beat
  typedef struct packed {
    logic [`AXI_DWIDTH-1:0] data;
    logic [`AXI_SWIDTH-1:0] strb;
  } dataBeatT;

endpackage

`default_nettype wire

// ==== rtl/regAccessIf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axiSlave_settings.svh"

interface regAccessIf;

  // write path, error comes back in the same cycle
  logic                   wrEn;
  logic [`AXI_AWIDTH-1:0] wrAddr;
  logic [`AXI_DWIDTH-1:0] wrData;
  logic [`AXI_SWIDTH-1:0] wrStrb;
  logic                   wrErr;

  // read path, data and error are registered one cycle after rdEn
  logic                   rdEn;
  logic [`AXI_AWIDTH-1:0] rdAddr;
  logic [`AXI_DWIDTH-1:0] rdData;
  logic                   rdErr;

  modport front (
    output wrEn, wrAddr, wrData, wrStrb,
    input  wrErr,
    output rdEn, rdAddr,
    input  rdData, rdErr
  );

  modport bank (
    input  wrEn, wrAddr, wrData, wrStrb,
    output wrErr,
    input  rdEn, rdAddr,
    output rdData, rdErr
  );

endinterface

`default_nettype wire

// ==== rtl/chanHold.sv ====
`timescale 1ns/1ps
`default_nettype none

module chanHold #(
  parameter type payloadT = logic
) (
  input  wire logic    ACLK,
  input  wire logic    ARESTn,
  input  wire logic    inValid,
  output logic         inReady,
  input  wire payloadT inBeat,
  output logic         full,
  output payloadT      beat,
  input  wire logic    releaseBeat
);

  logic capture;

  // ready is simply "holder empty", so it is high straight out of reset
  assign inReady = !full;
  assign capture = inValid && inReady;

  // occupancy flag
  always_ff @(posedge ACLK or negedge ARESTn) begin
    if (!ARESTn) begin
      full <= 1'b0;
    end else if (releaseBeat) begin
      full <= 1'b0;
    end else if (capture) begin
      full <= 1'b1;
    end
  end

  // payload only moves on a handshake
  always_ff @(posedge ACLK) begin
    if (capture) begin
      beat <= inBeat;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/regBank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axiSlave_settings.svh"

module regBank (
  input  wire logic ACLK,
  input  wire logic ARESTn,
  regAccessIf.bank  regs
);

  localparam int IDX_W = `AXI_AWIDTH - 2;

  // word 0 is the ID constant, so storage starts at 1
  logic [`AXI_DWIDTH-1:0] regFile [1:`REG_COUNT-1];
  logic [IDX_W-1:0]       wrIdx;
  logic [IDX_W-1:0]       rdIdx;
  logic                   rdBad;
  logic [`AXI_DWIDTH-1:0] rdWord;

  // byte address to word index, low two bits dropped
  assign wrIdx = regs.wrAddr[`AXI_AWIDTH-1:2];
  assign rdIdx = regs.rdAddr[`AXI_AWIDTH-1:2];

  // out of range, or an attempt to overwrite the ID word
  assign regs.wrErr = (wrIdx >= IDX_W'(`REG_COUNT)) || (wrIdx == '0);
  assign rdBad      = (rdIdx >= IDX_W'(`REG_COUNT));

  always_ff @(posedge ACLK or negedge ARESTn) begin
    if (!ARESTn) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regFile[i] <= '0;
      end
    end else if (regs.wrEn && !regs.wrErr) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        if (wrIdx == IDX_W'(i)) begin
          for (int b = 0; b < `AXI_SWIDTH; b++) begin
            if (regs.wrStrb[b]) begin
              regFile[i][8*b +: 8] <= regs.wrData[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // read mux, unmapped words read as zero
  always_comb begin
    rdWord = '0;
    if (rdIdx == '0) begin
      rdWord = `REG_ID_VALUE;
    end
    for (int i = 1; i < `REG_COUNT; i++) begin
      if (rdIdx == IDX_W'(i)) begin
        rdWord = regFile[i];
      end
    end
  end

  // Sampled before this edge's write lands, so a same-cycle read sees the old word.
  always_ff @(posedge ACLK) begin
    if (regs.rdEn) begin
      regs.rdData <= rdWord;
    end
  end

  always_ff @(posedge ACLK or negedge ARESTn) begin
    if (!ARESTn) begin
      regs.rdErr <= 1'b0;
    end else if (regs.rdEn) begin
      regs.rdErr <= rdBad;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/axiWriteFront.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axiSlave_settings.svh"

module axiWriteFront (
  input  wire logic                   ACLK,
  input  wire logic                   ARESTn,
  input  wire logic                   AWVALID,
  input  wire logic [`AXI_AWIDTH-1:0] AWADDR,
  output logic                        AWREADY,
  input  wire logic                   WVALID,
  input  wire logic [`AXI_DWIDTH-1:0] WDATA,
  input  wire logic [`AXI_SWIDTH-1:0] WSTRB,
  output logic                        WREADY,
  input  wire logic                   BREADY,
  output logic                        BVALID,
  output axiSlavePkg::respT           BRESP,
  regAccessIf.front                   regs
);

  import axiSlavePkg::*;

  typedef enum logic {
    IDLE,
    RESPOND
  } stateT;

  stateT    state;
  addrBeatT awIn;
  addrBeatT awHeld;
  dataBeatT wIn;
  dataBeatT wHeld;
  logic     awFull;
  logic     wFull;
  logic     bDone;

  assign awIn.addr = AWADDR;
  assign wIn.data  = WDATA;
  assign wIn.strb  = WSTRB;

  // AW and W are taken independently, order does not matter
  chanHold #(.payloadT(addrBeatT)) awHold (
    .ACLK        (ACLK),
    .ARESTn      (ARESTn),
    .inValid     (AWVALID),
    .inReady     (AWREADY),
    .inBeat      (awIn),
    .full        (awFull),
    .beat        (awHeld),
    .releaseBeat (bDone)
  );

  chanHold #(.payloadT(dataBeatT)) wHold (
    .ACLK        (ACLK),
    .ARESTn      (ARESTn),
    .inValid     (WVALID),
    .inReady     (WREADY),
    .inBeat      (wIn),
    .full        (wFull),
    .beat        (wHeld),
    .releaseBeat (bDone)
  );

  // one strobe in the first idle cycle with both beats held
  assign regs.wrEn   = (state == IDLE) && awFull && wFull;
  assign regs.wrAddr = awHeld.addr;
  assign regs.wrData = wHeld.data;
  assign regs.wrStrb = wHeld.strb;

  assign BVALID = (state == RESPOND);
  assign bDone  = BVALID && BREADY;

  always_ff @(posedge ACLK or negedge ARESTn) begin
    if (!ARESTn) begin
      state <= IDLE;
      BRESP <= OKAY;
    end else begin
      case (state)
        IDLE: begin
          if (regs.wrEn) begin
            state <= RESPOND;
            BRESP <= regs.wrErr ? SLVERR : OKAY;
          end
        end
        // BRESP stays put until the master takes it
        RESPOND: begin
          if (bDone) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/axiReadFront.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axiSlave_settings.svh"

module axiReadFront (
  input  wire logic                   ACLK,
  input  wire logic                   ARESTn,
  input  wire logic                   ARVALID,
  input  wire logic [`AXI_AWIDTH-1:0] ARADDR,
  output logic                        ARREADY,
  input  wire logic                   RREADY,
  output logic                        RVALID,
  output logic [`AXI_DWIDTH-1:0]      RDATA,
  output axiSlavePkg::respT           RRESP,
  regAccessIf.front                   regs
);

  import axiSlavePkg::*;

  typedef enum logic {
    IDLE,
    RESPOND
  } stateT;

  stateT    state;
  addrBeatT arIn;
  addrBeatT arHeld;
  logic     arFull;
  logic     rDone;

  assign arIn.addr = ARADDR;

  chanHold #(.payloadT(addrBeatT)) arHold (
    .ACLK        (ACLK),
    .ARESTn      (ARESTn),
    .inValid     (ARVALID),
    .inReady     (ARREADY),
    .inBeat      (arIn),
    .full        (arFull),
    .beat        (arHeld),
    .releaseBeat (rDone)
  );

  // strobe the bank once, the cycle after AR lands in the holder
  assign regs.rdEn   = (state == IDLE) && arFull;
  assign regs.rdAddr = arHeld.addr;

  // bank output only changes on rdEn, so it is stable while RVALID waits
  assign RVALID = (state == RESPOND);
  assign RDATA  = regs.rdData;
  assign RRESP  = regs.rdErr ? SLVERR : OKAY;
  assign rDone  = RVALID && RREADY;

  always_ff @(posedge ACLK or negedge ARESTn) begin
    if (!ARESTn) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (regs.rdEn) begin
            state <= RESPOND;
          end
        end
        RESPOND: begin
          if (rDone) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/axiLiteRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axiSlave_settings.svh"

module axiLiteRegs (
  input  wire logic                   ACLK,
  input  wire logic                   ARESTn,
  // write address
  input  wire logic                   AWVALID,
  output logic                        AWREADY,
  input  wire logic [`AXI_AWIDTH-1:0] AWADDR,
  // write data
  input  wire logic                   WVALID,
  output logic                        WREADY,
  input  wire logic [`AXI_DWIDTH-1:0] WDATA,
  input  wire logic [`AXI_SWIDTH-1:0] WSTRB,
  // write response
  input  wire logic                   BREADY,
  output logic                        BVALID,
  output axiSlavePkg::respT           BRESP,
  // read address
  input  wire logic                   ARVALID,
  output logic                        ARREADY,
  input  wire logic [`AXI_AWIDTH-1:0] ARADDR,
  // read data
  input  wire logic                   RREADY,
  output logic                        RVALID,
  output logic [`AXI_DWIDTH-1:0]      RDATA,
  output axiSlavePkg::respT           RRESP
);

  regAccessIf regsIf ();

  axiWriteFront writeFront (
    .ACLK    (ACLK),
    .ARESTn  (ARESTn),
    .AWVALID (AWVALID),
    .AWADDR  (AWADDR),
    .AWREADY (AWREADY),
    .WVALID  (WVALID),
    .WDATA   (WDATA),
    .WSTRB   (WSTRB),
    .WREADY  (WREADY),
    .BREADY  (BREADY),
    .BVALID  (BVALID),
    .BRESP   (BRESP),
    .regs    (regsIf.front)
  );

  axiReadFront readFront (
    .ACLK    (ACLK),
    .ARESTn  (ARESTn),
    .ARVALID (ARVALID),
    .ARADDR  (ARADDR),
    .ARREADY (ARREADY),
    .RREADY  (RREADY),
    .RVALID  (RVALID),
    .RDATA   (RDATA),
    .RRESP   (RRESP),
    .regs    (regsIf.front)
  );

  regBank bank (
    .ACLK   (ACLK),
    .ARESTn (ARESTn),
    .regs   (regsIf.bank)
  );

endmodule

`default_nettype wire

// ==== dv/axiLiteRegs_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axiSlave_settings.svh"

module axiLiteRegs_checker (
  input wire logic                   ACLK,
  input wire logic                   ARESTn,
  input wire logic                   AWVALID,
  input wire logic                   AWREADY,
  input wire logic                   WVALID,
  input wire logic                   WREADY,
  input wire logic                   BREADY,
  input wire logic                   BVALID,
  input wire axiSlavePkg::respT      BRESP,
  input wire logic                   ARVALID,
  input wire logic                   ARREADY,
  input wire logic                   RREADY,
  input wire logic                   RVALID,
  input wire logic [`AXI_DWIDTH-1:0] RDATA,
  input wire axiSlavePkg::respT      RRESP
);

  int failCount = 0;

  // holders empty and no response pending right out of reset
  readyAfterReset: assert property (@(posedge ACLK)
    $rose(ARESTn) |-> AWREADY && WREADY && ARREADY && !BVALID && !RVALID)
    else begin failCount++; $error("ready or valid wrong after reset"); end

  bStable: assert property (@(posedge ACLK) disable iff (!ARESTn)
    BVALID && !BREADY |=> BVALID && $stable(BRESP))
    else begin failCount++; $error("B response changed before BREADY"); end

  rStable: assert property (@(posedge ACLK) disable iff (!ARESTn)
    RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RRESP))
    else begin failCount++; $error("R response changed before RREADY"); end

  // each ready drops in the cycle after its beat is taken
  awTaken: assert property (@(posedge ACLK) disable iff (!ARESTn)
    AWVALID && AWREADY |=> !AWREADY)
    else begin failCount++; $error("AWREADY stayed high after an AW beat"); end

  wTaken: assert property (@(posedge ACLK) disable iff (!ARESTn)
    WVALID && WREADY |=> !WREADY)
    else begin failCount++; $error("WREADY stayed high after a W beat"); end

  arTaken: assert property (@(posedge ACLK) disable iff (!ARESTn)
    ARVALID && ARREADY |=> !ARREADY)
    else begin failCount++; $error("ARREADY stayed high after an AR beat"); end

  // a captured beat blocks its channel until the B handshake
  awBlocked: assert property (@(posedge ACLK) disable iff (!ARESTn)
    !AWREADY && !(BVALID && BREADY) |=> !AWREADY)
    else begin failCount++; $error("AWREADY rose without a B handshake"); end

  wBlocked: assert property (@(posedge ACLK) disable iff (!ARESTn)
    !WREADY && !(BVALID && BREADY) |=> !WREADY)
    else begin failCount++; $error("WREADY rose without a B handshake"); end

  readyAfterB: assert property (@(posedge ACLK) disable iff (!ARESTn)
    BVALID && BREADY |=> AWREADY && WREADY)
    else begin failCount++; $error("write channels not free after B"); end

  rTiming: assert property (@(posedge ACLK) disable iff (!ARESTn)
    ARVALID && ARREADY |-> ##2 $rose(RVALID))
    else begin failCount++; $error("RVALID not two cycles after AR"); end

endmodule

bind axiLiteRegs axiLiteRegs_checker protoCheck (.*);

`default_nettype wire

// ==== dv/axiLiteRegs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axiSlave_settings.svh"

module axiLiteRegs_tb;

  import axiSlavePkg::*;

  typedef logic [`AXI_AWIDTH-1:0] addrT;

  // 1 + 30 + 5 + 12 + 8 transactions over the five tests
  localparam int TXN_COUNT = 56;
  localparam int IDX_BITS = $clog2(`REG_COUNT);

  logic                   ACLK = 1'b0;
  logic                   ARESTn;
  logic                   AWVALID, WVALID, BREADY, ARVALID, RREADY;
  logic                   AWREADY, WREADY, BVALID, ARREADY, RVALID;
  addrT                   AWADDR, ARADDR;
  logic [`AXI_DWIDTH-1:0] WDATA, RDATA;
  logic [`AXI_SWIDTH-1:0] WSTRB;
  respT                   BRESP, RRESP;

  logic [31:0]            lfsr = 32'h1d6a_a415;
  logic [`AXI_DWIDTH-1:0] model [0:`REG_COUNT-1];
  // the write and the read currently in flight
  addrT                   wrAddr, rdAddr;
  logic [`AXI_DWIDTH-1:0] wrData;
  logic [`AXI_SWIDTH-1:0] wrStrb;
  respT                   expBresp, expRresp;
  logic [`AXI_DWIDTH-1:0] expRdata;
  int                     errors = 0;
  int                     testErrBase = 0;
  int                     testCount = 0;

  axiLiteRegs axiLiteRegs_inst (.*);

  always #2 ACLK = ~ACLK;

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
    end
    return r;
  endfunction

  function automatic logic inBank(input addrT a);
    return (a >> 2) < `REG_COUNT;
  endfunction

  // word 0 holds the ID and takes no writes
  function automatic logic writable(input addrT a);
    return inBank(a) && (a >> 2) != 0;
  endfunction

  // low address bits are ignored by the bank, so randomize them
  function automatic addrT wordAddr(input int idx);
    return addrT'(idx * 4) | addrT'(randBits(2));
  endfunction

  assign expBresp = writable(wrAddr) ? OKAY : SLVERR;
  assign expRresp = inBank(rdAddr) ? OKAY : SLVERR;
  assign expRdata = model[rdAddr[2 +: IDX_BITS]];

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("Fail t=%0t %s expected %h actual %h", $time, name, exp, act);
    errors++;
  endtask

  bRespOk: assert property (@(posedge ACLK) disable iff (!ARESTn)
    BVALID |-> BRESP == expBresp)
    else mismatch("BRESP", 32'($sampled(expBresp)), 32'($sampled(BRESP)));

  rRespOk: assert property (@(posedge ACLK) disable iff (!ARESTn)
    RVALID && RREADY |-> RRESP == expRresp)
    else mismatch("RRESP", 32'($sampled(expRresp)), 32'($sampled(RRESP)));

  rDataOk: assert property (@(posedge ACLK) disable iff (!ARESTn)
    RVALID && RREADY && expRresp == OKAY |-> RDATA == expRdata)
    else mismatch("RDATA", $sampled(expRdata), $sampled(RDATA));

  // channel tasks start on a falling edge, ready is stable there
  task automatic sendAw(input addrT addr);
    AWVALID = 1'b1;
    AWADDR  = addr;
    while (!AWREADY) @(negedge ACLK);
    @(negedge ACLK);
    AWVALID = 1'b0;
  endtask

  task automatic sendW(input logic [`AXI_DWIDTH-1:0] data, input logic [`AXI_SWIDTH-1:0] strb);
    WVALID = 1'b1;
    WDATA  = data;
    WSTRB  = strb;
    while (!WREADY) @(negedge ACLK);
    @(negedge ACLK);
    WVALID = 1'b0;
  endtask

  // order 0 is AW first, 1 is W first, 2 is both at once
  task automatic doWrite(input addrT addr, input int order, input int stall);
    wrAddr = addr;
    wrData = randBits(`AXI_DWIDTH);
    wrStrb = randBits(`AXI_SWIDTH);
    if (order == 0) begin
      sendAw(addr);
      sendW(wrData, wrStrb);
    end else if (order == 1) begin
      sendW(wrData, wrStrb);
      sendAw(addr);
    end else begin
      fork
        sendAw(addr);
        sendW(wrData, wrStrb);
      join
    end
    while (!BVALID) @(negedge ACLK);
    repeat (stall) @(negedge ACLK);
    BREADY = 1'b1;
    @(negedge ACLK);
    BREADY = 1'b0;
    // B handshake just happened, merge the strobed bytes
    if (writable(addr)) begin
      for (int b = 0; b < `AXI_SWIDTH; b++) begin
        if (wrStrb[b]) begin
          model[addr[2 +: IDX_BITS]][8*b +: 8] = wrData[8*b +: 8];
        end
      end
    end
  endtask

  task automatic doRead(input addrT addr, input int stall);
    rdAddr  = addr;
    ARVALID = 1'b1;
    ARADDR  = addr;
    while (!ARREADY) @(negedge ACLK);
    @(negedge ACLK);
    ARVALID = 1'b0;
    while (!RVALID) @(negedge ACLK);
    repeat (stall) @(negedge ACLK);
    RREADY = 1'b1;
    @(negedge ACLK);
    RREADY = 1'b0;
  endtask

  task automatic endTest(input string name);
    int found;
    found = errors + axiLiteRegs_inst.protoCheck.failCount - testErrBase;
    $display("test %0d %-24s done, %0d errors", testCount + 1, name, found);
    testErrBase += found;
    testCount++;
  endtask

  initial begin
    int   wIdx;
    int   rIdx;
    addrT a;
    addrT b;
    int   total;
    ARESTn  = 1'b0;
    AWVALID = 1'b0;
    AWADDR  = '0;
    WVALID  = 1'b0;
    WDATA   = '0;
    WSTRB   = '0;
    BREADY  = 1'b0;
    ARVALID = 1'b0;
    ARADDR  = '0;
    RREADY  = 1'b0;
    wrAddr  = '0;
    rdAddr  = '0;
    wrData  = '0;
    wrStrb  = '0;
    model[0] = `REG_ID_VALUE;
    for (int i = 1; i < `REG_COUNT; i++) begin
      model[i] = '0;
    end
    repeat (3) @(negedge ACLK);
    ARESTn = 1'b1;

    doRead(wordAddr(0), 0);
    endTest("reset and ID word");

    for (int order = 0; order < 3; order++) begin
      for (int n = 0; n < 5; n++) begin
        wIdx = 1 + randBits(4) % 15;
        a = wordAddr(wIdx);
        doWrite(a, order, 0);
        doRead(a, 0);
      end
    end
    endTest("strobed writes");

    a = wordAddr(0);
    doWrite(a, 2, 0);
    doRead(a, 0);
    a = wordAddr(`REG_COUNT + randBits(8));
    doWrite(a, 2, 0);
    doRead(a, 0);
    doRead(16'hFFFC, 0);
    endTest("SLVERR cases");

    // random stalls on BREADY and RREADY
    for (int n = 0; n < 6; n++) begin
      a = wordAddr(1 + randBits(4) % 15);
      doWrite(a, randBits(2) % 3, randBits(3));
      doRead(a, randBits(3));
    end
    endTest("back-pressure");

    // read of one word while another word is written
    for (int n = 0; n < 4; n++) begin
      wIdx = 1 + randBits(4) % 15;
      rIdx = wIdx % 15 + 1;
      a = wordAddr(wIdx);
      b = wordAddr(rIdx);
      fork
        doWrite(a, 2, 0);
        doRead(b, 0);
      join
    end
    endTest("overlapped read and write");

    total = errors + axiLiteRegs_inst.protoCheck.failCount;
    $display("%0d tests, %0d data errors, %0d protocol errors", testCount, errors,
             axiLiteRegs_inst.protoCheck.failCount);
    if (total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // 400 cycles per transaction is far beyond any legal response time
  initial begin
    #(TXN_COUNT * 400 * 4);
    $display("timeout, the DUT stopped answering before all tests finished");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+rtl
rtl/axiSlavePkg.sv
rtl/regAccessIf.sv
rtl/chanHold.sv
rtl/regBank.sv
rtl/axiWriteFront.sv
rtl/axiReadFront.sv
rtl/axiLiteRegs.sv
dv/axiLiteRegs_checker.sv
dv/axiLiteRegs_tb.sv

// ==== Bender.yml ====
package:
  name: axi_lite_regs

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axiSlavePkg.sv
      - rtl/regAccessIf.sv
      - rtl/chanHold.sv
      - rtl/regBank.sv
      - rtl/axiWriteFront.sv
      - rtl/axiReadFront.sv
      - rtl/axiLiteRegs.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/axiLiteRegs_checker.sv
      - dv/axiLiteRegs_tb.sv
